// ==== hw/vliw_decoder_pkg.sv ====
`default_nettype none

package vliw_decoder_pkg;

    // ==========================================================================
    // Widths
    // ==========================================================================
    localparam int SLOT_COUNT       = 3;
    localparam int SLOT_WIDTH       = 32;
    localparam int VLIW_WIDTH       = SLOT_COUNT * SLOT_WIDTH;
    localparam int REG_ADDR_WIDTH   = 4;    // Two trits
    localparam int IMM_WIDTH        = 8;    // Four trits
    localparam int WORD_WIDTH       = 32;
    localparam int ALU_OP_WIDTH     = 4;
    localparam int ERROR_CODE_WIDTH = 4;
    localparam int STATE_WIDTH      = 3;

    // Trit positions inside one slot, counted from bit 0
    localparam int TRIT_COUNT    = SLOT_WIDTH / 2;
    localparam int IMM_TRITS     = IMM_WIDTH / 2;
    localparam int OPERAND_TRITS = (3 * REG_ADDR_WIDTH + IMM_WIDTH) / 2;

    // ==========================================================================
    // Opcode table
    // ==========================================================================
    localparam logic [3:0] CAT_ALU     = 4'h1;
    localparam logic [3:0] CAT_MEMORY  = 4'h2;
    localparam logic [3:0] CAT_BRANCH  = 4'h3;
    localparam logic [3:0] CAT_SPECIAL = 4'h4;

    // Arithmetic and logic codes are contiguous runs
    localparam logic [7:0] ALU_ADD       = 8'h11;
    localparam logic [7:0] ALU_SUB       = 8'h12;
    localparam logic [7:0] ALU_MUL       = 8'h13;
    localparam logic [7:0] ALU_DIV       = 8'h14;
    localparam logic [7:0] ALU_MOD       = 8'h15;
    localparam logic [7:0] ALU_NEG       = 8'h16;
    localparam logic [7:0] ALU_ABS       = 8'h17;
    localparam logic [7:0] ALU_CMP       = 8'h18;
    localparam logic [7:0] ALU_MAX       = 8'h19;
    localparam logic [7:0] ALU_MIN       = 8'h1A;
    localparam logic [7:0] ALU_INC       = 8'h1B;
    localparam logic [7:0] ALU_DEC       = 8'h1C;
    localparam logic [7:0] LOG_AND       = 8'h21;
    localparam logic [7:0] LOG_OR        = 8'h22;
    localparam logic [7:0] LOG_NOT       = 8'h23;
    localparam logic [7:0] LOG_NAND      = 8'h24;
    localparam logic [7:0] LOG_NOR       = 8'h25;
    localparam logic [7:0] LOG_XOR       = 8'h26;
    localparam logic [7:0] LOG_CONSENSUS = 8'h27;
    localparam logic [7:0] LOG_MAJORITY  = 8'h28;

    localparam logic [7:0] MEM_LOAD     = 8'h41;
    localparam logic [7:0] MEM_STORE    = 8'h42;
    localparam logic [7:0] MEM_LOAD_IMM = 8'h43;
    localparam logic [7:0] MEM_PUSH     = 8'h44;
    localparam logic [7:0] MEM_POP      = 8'h45;

    localparam logic [7:0] BR_JUMP      = 8'h61;
    localparam logic [7:0] BR_JUMP_REG  = 8'h62;
    localparam logic [7:0] BR_BRANCH_EQ = 8'h63;
    localparam logic [7:0] BR_BRANCH_NE = 8'h64;
    localparam logic [7:0] BR_BRANCH_GT = 8'h65;
    localparam logic [7:0] BR_BRANCH_LT = 8'h66;
    localparam logic [7:0] BR_BRANCH_GE = 8'h67;
    localparam logic [7:0] BR_BRANCH_LE = 8'h68;
    localparam logic [7:0] BR_CALL      = 8'h69;
    localparam logic [7:0] BR_RETURN    = 8'h6A;

    localparam logic [7:0] SP_NOP  = 8'h80;
    localparam logic [7:0] SP_HALT = 8'h81;
    localparam logic [7:0] SP_INT  = 8'h82;
    localparam logic [7:0] SP_IRET = 8'h83;

    // Branch conditions and error codes
    localparam logic [2:0] BR_COND_EQ   = 3'd0;
    localparam logic [2:0] BR_COND_NE   = 3'd1;
    localparam logic [2:0] BR_COND_GT   = 3'd2;
    localparam logic [2:0] BR_COND_LT   = 3'd3;
    localparam logic [2:0] BR_COND_GE   = 3'd4;
    localparam logic [2:0] BR_COND_LE   = 3'd5;
    localparam logic [2:0] BR_COND_NONE = 3'd7;

    localparam logic [ERROR_CODE_WIDTH-1:0] ERR_NONE         = 4'd0;
    localparam logic [ERROR_CODE_WIDTH-1:0] ERR_INVALID_OP   = 4'd2;
    localparam logic [ERROR_CODE_WIDTH-1:0] ERR_INVALID_ADDR = 4'd3;

    // Sequencer states, decode states consecutive so the FSM can step by one
    localparam logic [STATE_WIDTH-1:0] ST_IDLE     = 3'd0;
    localparam logic [STATE_WIDTH-1:0] ST_DECODE_A = 3'd1;
    localparam logic [STATE_WIDTH-1:0] ST_DECODE_B = 3'd2;
    localparam logic [STATE_WIDTH-1:0] ST_DECODE_C = 3'd3;
    localparam logic [STATE_WIDTH-1:0] ST_COMPLETE = 3'd4;
    localparam logic [STATE_WIDTH-1:0] ST_ERROR    = 3'd5;

    // One slot, seen as instruction fields or as sixteen trits
    typedef union packed {
        struct packed {
            logic [3:0]                category;
            logic [7:0]                operation;
            logic [REG_ADDR_WIDTH-1:0] rs1;
            logic [REG_ADDR_WIDTH-1:0] rs2;
            logic [REG_ADDR_WIDTH-1:0] rs3;
            logic [IMM_WIDTH-1:0]      imm;
        } fields;
        logic [TRIT_COUNT-1:0][1:0] trits;
    } slot_word_u;

endpackage

`default_nettype wire

// ==== hw/slot_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_checker import vliw_decoder_pkg::*; (
    input  slot_word_u                  slot_word,
    output logic [ERROR_CODE_WIDTH-1:0] slot_fault
);

    logic op_ok;
    logic reg_bad;
    logic imm_bad;

    // Opcode is plain binary, looked up per category
    always_comb begin
        case (slot_word.fields.category)
            CAT_ALU: op_ok = slot_word.fields.operation inside
                             {[ALU_ADD:ALU_DEC], [LOG_AND:LOG_MAJORITY]};
            CAT_MEMORY:  op_ok = slot_word.fields.operation inside {[MEM_LOAD:MEM_POP]};
            CAT_BRANCH:  op_ok = slot_word.fields.operation inside {[BR_JUMP:BR_RETURN]};
            CAT_SPECIAL: op_ok = slot_word.fields.operation inside {[SP_NOP:SP_IRET]};
            default:     op_ok = 1'b0;
        endcase
    end

    // Operand trits only, the opcode bits are not ternary
    always_comb begin
        reg_bad = 1'b0;
        imm_bad = 1'b0;
        for (int i = 0; i < OPERAND_TRITS; i++) begin
            if (slot_word.trits[i] == 2'b11) begin
                if (i < IMM_TRITS) begin
                    imm_bad = 1'b1;
                end else begin
                    reg_bad = 1'b1;     // rs3, rs2 or rs1
                end
            end
        end
    end

    always_comb begin
        if (!op_ok) begin
            slot_fault = ERR_INVALID_OP;
        end else if (reg_bad) begin
            slot_fault = ERR_INVALID_ADDR;
        end else if (imm_bad) begin
            slot_fault = ERR_INVALID_OP;
        end else begin
            slot_fault = ERR_NONE;
        end
    end

endmodule

`default_nettype wire

// ==== hw/slot_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_decoder import vliw_decoder_pkg::*; (
    input  slot_word_u                  slot_word,
    output logic                        alu_enable,
    output logic [ALU_OP_WIDTH-1:0]     alu_operation,
    output logic                        memory_enable,
    output logic                        memory_write,
    output logic [REG_ADDR_WIDTH-1:0]   rd,
    output logic                        branch_enable,
    output logic [2:0]                  branch_condition,
    output logic [WORD_WIDTH-1:0]       branch_target
);

    logic [7:0] op;

    assign op = slot_word.fields.operation;

    always_comb begin
        alu_enable       = 1'b0;
        alu_operation    = '0;
        memory_enable    = 1'b0;
        memory_write     = 1'b0;
        rd               = slot_word.fields.rs3;   // Default destination
        branch_enable    = 1'b0;
        branch_condition = '0;
        branch_target    = '0;

        case (slot_word.fields.category)
            CAT_ALU: begin
                alu_enable    = 1'b1;
                // Both runs start at low nibble 1, so index is nibble minus one
                alu_operation = op[ALU_OP_WIDTH-1:0] - 4'd1;
            end

            CAT_MEMORY: begin
                memory_enable = 1'b1;
                case (op)
                    MEM_STORE, MEM_PUSH: begin
                        memory_write = 1'b1;
                        rd           = '0;
                    end
                    MEM_LOAD_IMM, MEM_POP: rd = slot_word.fields.rs1;
                    default: ;                      // LOAD keeps rs3
                endcase
            end

            CAT_BRANCH: begin
                branch_enable = 1'b1;
                case (op)
                    BR_BRANCH_EQ: branch_condition = BR_COND_EQ;
                    BR_BRANCH_NE: branch_condition = BR_COND_NE;
                    BR_BRANCH_GT: branch_condition = BR_COND_GT;
                    BR_BRANCH_LT: branch_condition = BR_COND_LT;
                    BR_BRANCH_GE: branch_condition = BR_COND_GE;
                    BR_BRANCH_LE: branch_condition = BR_COND_LE;
                    default:      branch_condition = BR_COND_NONE;
                endcase
                // Register jumps resolve their target in the execute stage
                if (op != BR_JUMP_REG) begin
                    branch_target = {{(WORD_WIDTH-IMM_WIDTH){slot_word.fields.imm[IMM_WIDTH-1]}},
                                     slot_word.fields.imm};
                end
            end

            default: ;                              // Special ops drive no unit
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/decode_result_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_result_bank import vliw_decoder_pkg::*; (
    input  wire                                              clk,
    input  wire                                              rst_n,
    input  wire  [1:0]                                       slot_sel,
    input  wire                                              capture,
    input  wire                                              clear_results,
    input  wire                                              dec_alu_enable,
    input  wire  [ALU_OP_WIDTH-1:0]                          dec_alu_operation,
    input  wire                                              dec_memory_enable,
    input  wire                                              dec_memory_write,
    input  wire  [REG_ADDR_WIDTH-1:0]                        dec_rd,
    input  wire                                              dec_branch_enable,
    input  wire  [2:0]                                       dec_branch_condition,
    input  wire  [WORD_WIDTH-1:0]                            dec_branch_target,
    input  slot_word_u                                       slot_word,
    output logic [SLOT_COUNT-1:0]                            alu_enable,
    output logic [SLOT_COUNT-1:0][ALU_OP_WIDTH-1:0]          alu_operation,
    output logic [SLOT_COUNT-1:0]                            memory_enable,
    output logic [SLOT_COUNT-1:0]                            memory_write,
    output logic [SLOT_COUNT-1:0][REG_ADDR_WIDTH-1:0]        rs1,
    output logic [SLOT_COUNT-1:0][REG_ADDR_WIDTH-1:0]        rs2,
    output logic [SLOT_COUNT-1:0][REG_ADDR_WIDTH-1:0]        rd,
    output logic [SLOT_COUNT-1:0][IMM_WIDTH-1:0]             immediate,
    output logic                                             branch_enable,
    output logic [2:0]                                       branch_condition,
    output logic [WORD_WIDTH-1:0]                            branch_target
);

    // Unit enables
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_enable    <= '0;
            memory_enable <= '0;
            memory_write  <= '0;
            branch_enable <= 1'b0;
        end else if (clear_results) begin
            alu_enable    <= '0;
            memory_enable <= '0;
            memory_write  <= '0;
            branch_enable <= 1'b0;
        end else if (capture) begin
            alu_enable[slot_sel]    <= dec_alu_enable;
            memory_enable[slot_sel] <= dec_memory_enable;
            memory_write[slot_sel]  <= dec_memory_write;
            if (slot_sel == 2'd0) begin
                branch_enable <= dec_branch_enable;  // Branches issue from slot A only
            end
        end
    end

    // Operand fields and branch payload
    always_ff @(posedge clk) begin
        if (clear_results) begin
            alu_operation    <= '0;
            rs1              <= '0;
            rs2              <= '0;
            rd               <= '0;
            immediate        <= '0;
            branch_condition <= '0;
            branch_target    <= '0;
        end else if (capture) begin
            alu_operation[slot_sel] <= dec_alu_operation;
            rs1[slot_sel]           <= slot_word.fields.rs1;
            rs2[slot_sel]           <= slot_word.fields.rs2;
            rd[slot_sel]            <= dec_rd;
            immediate[slot_sel]     <= slot_word.fields.imm;
            if (slot_sel == 2'd0) begin
                branch_condition <= dec_branch_condition;
                branch_target    <= dec_branch_target;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/decode_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_sequencer import vliw_decoder_pkg::*; (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         req,
    input  wire  [VLIW_WIDTH-1:0]       instruction,
    input  wire                         error_clear,
    input  wire  [ERROR_CODE_WIDTH-1:0] slot_fault,
    output logic                        ack,
    output slot_word_u                  slot_word,
    output logic [1:0]                  slot_sel,
    output logic                        capture,
    output logic                        clear_results,
    output logic                        error,
    output logic [ERROR_CODE_WIDTH-1:0] error_code,
    output logic [31:0]                 decode_count,
    output logic [31:0]                 error_count
);

    logic [STATE_WIDTH-1:0] state;
    logic                   decoding;
    logic                   fault;

    assign decoding = (state == ST_DECODE_A) || (state == ST_DECODE_B) ||
                      (state == ST_DECODE_C);
    assign fault    = (slot_fault != ERR_NONE);

    // Slot under test follows the decode state
    always_comb begin
        case (state)
            ST_DECODE_B: slot_sel = 2'd1;
            ST_DECODE_C: slot_sel = 2'd2;
            default:     slot_sel = 2'd0;
        endcase
    end

    assign slot_word = instruction[slot_sel*SLOT_WIDTH +: SLOT_WIDTH];

    assign capture       = decoding && !fault;
    assign clear_results = ((state == ST_IDLE) && req) || (decoding && fault);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            ack          <= 1'b0;
            error        <= 1'b0;
            error_code   <= ERR_NONE;
            decode_count <= '0;
            error_count  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state        <= ST_DECODE_A;
                        decode_count <= decode_count + 32'd1;
                    end
                end

                ST_DECODE_A, ST_DECODE_B, ST_DECODE_C: begin
                    if (fault) begin
                        state       <= ST_ERROR;
                        ack         <= 1'b1;    // Ends the bundle early
                        error       <= 1'b1;
                        error_code  <= slot_fault;
                        error_count <= error_count + 32'd1;
                    end else begin
                        state <= state + 1'b1;  // C steps into COMPLETE
                    end
                end

                // Branch fields were taken with slot A, so only the handshake is left
                ST_COMPLETE: begin
                    if (!ack) begin
                        ack <= 1'b1;
                    end else if (!req) begin
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end

                ST_ERROR: begin
                    if (ack && !req) begin
                        ack <= 1'b0;
                    end
                    if (error_clear) begin
                        state      <= ST_IDLE;
                        ack        <= 1'b0;
                        error      <= 1'b0;
                        error_code <= ERR_NONE;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/vliw_decoder_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vliw_decoder_top import vliw_decoder_pkg::*; (
    input  wire                                       clk,
    input  wire                                       rst_n,
    input  wire                                       req,
    input  wire  [VLIW_WIDTH-1:0]                     instruction,
    input  wire                                       error_clear,
    output wire                                       ack,
    output wire  [SLOT_COUNT-1:0]                     alu_enable,
    output wire  [SLOT_COUNT-1:0][ALU_OP_WIDTH-1:0]   alu_operation,
    output wire  [SLOT_COUNT-1:0]                     memory_enable,
    output wire  [SLOT_COUNT-1:0]                     memory_write,
    output wire  [SLOT_COUNT-1:0][REG_ADDR_WIDTH-1:0] rs1,
    output wire  [SLOT_COUNT-1:0][REG_ADDR_WIDTH-1:0] rs2,
    output wire  [SLOT_COUNT-1:0][REG_ADDR_WIDTH-1:0] rd,
    output wire  [SLOT_COUNT-1:0][IMM_WIDTH-1:0]      immediate,
    output wire                                       branch_enable,
    output wire  [2:0]                                branch_condition,
    output wire  [WORD_WIDTH-1:0]                     branch_target,
    output wire                                       error,
    output wire  [ERROR_CODE_WIDTH-1:0]               error_code,
    output wire  [31:0]                               decode_count,
    output wire  [31:0]                               error_count
);

    slot_word_u                  slot_word;
    wire [1:0]                   slot_sel;
    wire                         capture;
    wire                         clear_results;
    wire [ERROR_CODE_WIDTH-1:0]  slot_fault;

    // Decoded controls of the selected slot
    wire                         dec_alu_enable;
    wire [ALU_OP_WIDTH-1:0]      dec_alu_operation;
    wire                         dec_memory_enable;
    wire                         dec_memory_write;
    wire [REG_ADDR_WIDTH-1:0]    dec_rd;
    wire                         dec_branch_enable;
    wire [2:0]                   dec_branch_condition;
    wire [WORD_WIDTH-1:0]        dec_branch_target;

    decode_sequencer u_sequencer (
        .clk, .rst_n, .req, .instruction, .error_clear, .slot_fault,
        .ack, .slot_word, .slot_sel, .capture, .clear_results,
        .error, .error_code, .decode_count, .error_count
    );

    slot_checker u_checker (
        .slot_word,
        .slot_fault
    );

    slot_decoder u_decoder (
        .slot_word,
        .alu_enable       (dec_alu_enable),
        .alu_operation    (dec_alu_operation),
        .memory_enable    (dec_memory_enable),
        .memory_write     (dec_memory_write),
        .rd               (dec_rd),
        .branch_enable    (dec_branch_enable),
        .branch_condition (dec_branch_condition),
        .branch_target    (dec_branch_target)
    );

    decode_result_bank u_results (
        .clk, .rst_n, .slot_sel, .capture, .clear_results,
        .dec_alu_enable, .dec_alu_operation, .dec_memory_enable, .dec_memory_write,
        .dec_rd, .dec_branch_enable, .dec_branch_condition, .dec_branch_target,
        .slot_word,
        .alu_enable, .alu_operation, .memory_enable, .memory_write,
        .rs1, .rs2, .rd, .immediate,
        .branch_enable, .branch_condition, .branch_target
    );

endmodule

`default_nettype wire

// ==== test/tb_instr_gen.svh ====
`ifndef TB_INSTR_GEN_SVH
`define TB_INSTR_GEN_SVH

// ==========================================================================
// Stimulus generation
// ==========================================================================
logic [31:0] lcg_state;

function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic logic [31:0] make_slot(input logic [11:0] opc, input logic [3:0] r1,
                                          input logic [3:0] r2, input logic [3:0] r3,
                                          input logic [7:0] imm);
    return {opc, r1, r2, r3, imm};
endfunction

// Index into the 39 table entries, walked category by category
function automatic logic [11:0] random_opcode();
    logic [7:0]  idx;
    logic [11:0] opc;
    idx = 8'((next_rand() >> 16) % 32'd39);
    if (idx < 8'd12) begin
        opc = {CAT_ALU, ALU_ADD + idx};
    end else if (idx < 8'd20) begin
        opc = {CAT_ALU, LOG_AND + idx - 8'd12};
    end else if (idx < 8'd25) begin
        opc = {CAT_MEMORY, MEM_LOAD + idx - 8'd20};
    end else if (idx < 8'd35) begin
        opc = {CAT_BRANCH, BR_JUMP + idx - 8'd25};
    end else begin
        opc = {CAT_SPECIAL, SP_NOP + idx - 8'd35};
    end
    return opc;
endfunction

// Legal trits only: 00, 01 or 10
function automatic logic [7:0] random_trits(input int n);
    logic [7:0] v;
    v = 8'd0;
    for (int i = 0; i < n; i++) begin
        v[2*i +: 2] = 2'((next_rand() >> 16) % 32'd3);
    end
    return v;
endfunction

function automatic logic [31:0] random_slot();
    logic [11:0] opc;
    logic [3:0]  r1;
    logic [3:0]  r2;
    logic [3:0]  r3;
    opc = random_opcode();
    r1  = 4'(random_trits(2));
    r2  = 4'(random_trits(2));
    r3  = 4'(random_trits(2));
    return make_slot(opc, r1, r2, r3, random_trits(4));
endfunction

function automatic logic [VLIW_WIDTH-1:0] random_bundle();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    a = random_slot();
    b = random_slot();
    c = random_slot();
    return {c, b, a};
endfunction

// ==========================================================================
// Reference model
// ==========================================================================
function automatic logic [3:0] expect_alu_op(input logic [31:0] s);
    logic [3:0] r;
    r = 4'd0;
    if (s[31:28] == CAT_ALU) begin
        if (s[27:20] >= LOG_AND) begin
            r = 4'(s[27:20] - LOG_AND);     // AND=0 up to MAJORITY=7
        end else begin
            r = 4'(s[27:20] - ALU_ADD);     // ADD=0 up to DEC=11
        end
    end
    return r;
endfunction

function automatic logic [3:0] expect_rd(input logic [31:0] s);
    logic [3:0] r;
    r = s[11:8];
    if (s[31:28] == CAT_MEMORY) begin
        case (s[27:20])
            MEM_STORE, MEM_PUSH:   r = 4'h0;
            MEM_LOAD_IMM, MEM_POP: r = s[19:16];
            default:               r = s[11:8];
        endcase
    end
    return r;
endfunction

function automatic logic [2:0] expect_cond(input logic [31:0] s);
    logic [2:0] r;
    r = 3'd0;
    if (s[31:28] == CAT_BRANCH) begin
        case (s[27:20])
            BR_BRANCH_EQ: r = BR_COND_EQ;
            BR_BRANCH_NE: r = BR_COND_NE;
            BR_BRANCH_GT: r = BR_COND_GT;
            BR_BRANCH_LT: r = BR_COND_LT;
            BR_BRANCH_GE: r = BR_COND_GE;
            BR_BRANCH_LE: r = BR_COND_LE;
            default:      r = BR_COND_NONE;
        endcase
    end
    return r;
endfunction

function automatic logic [31:0] expect_target(input logic [31:0] s);
    logic [31:0] t;
    t = 32'd0;
    if (s[31:28] == CAT_BRANCH && s[27:20] != BR_JUMP_REG) begin
        t = {{24{s[7]}}, s[7:0]};   // Sign-extended immediate
    end
    return t;
endfunction

`endif

// ==== test/tb_vliw_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vliw_decoder import vliw_decoder_pkg::*; ();

    localparam int ACK_TIMEOUT   = 40;
    localparam int IGNORE_CYCLES = 30;

    logic                  clk;
    logic                  rst_n;
    logic                  req;
    logic                  error_clear;
    logic [VLIW_WIDTH-1:0] instruction;

    wire                                       ack;
    wire  [SLOT_COUNT-1:0]                     alu_enable;
    wire  [SLOT_COUNT-1:0][ALU_OP_WIDTH-1:0]   alu_operation;
    wire  [SLOT_COUNT-1:0]                     memory_enable;
    wire  [SLOT_COUNT-1:0]                     memory_write;
    wire  [SLOT_COUNT-1:0][REG_ADDR_WIDTH-1:0] rs1;
    wire  [SLOT_COUNT-1:0][REG_ADDR_WIDTH-1:0] rs2;
    wire  [SLOT_COUNT-1:0][REG_ADDR_WIDTH-1:0] rd;
    wire  [SLOT_COUNT-1:0][IMM_WIDTH-1:0]      immediate;
    wire                                       branch_enable;
    wire  [2:0]                                branch_condition;
    wire  [WORD_WIDTH-1:0]                     branch_target;
    wire                                       error;
    wire  [ERROR_CODE_WIDTH-1:0]               error_code;
    wire  [31:0]                               decode_count;
    wire  [31:0]                               error_count;

    int bundles_sent;
    int faults_seen;

    `include "tb_instr_gen.svh"

    vliw_decoder_top uut (
        .clk, .rst_n, .req, .instruction, .error_clear,
        .ack, .alu_enable, .alu_operation, .memory_enable, .memory_write,
        .rs1, .rs2, .rd, .immediate,
        .branch_enable, .branch_condition, .branch_target,
        .error, .error_code, .decode_count, .error_count
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==========================================================================
    // Checks and handshake helpers
    // ==========================================================================
    task automatic fail_with(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else fail_with($sformatf("error: %s expected 0x%h got 0x%h", name, expected, actual));
    endtask

    task automatic wait_ack(input logic level, output int edges);
        edges = 0;
        while (ack !== level) begin
            @(negedge clk);
            edges++;
            if (edges > ACK_TIMEOUT) begin
                fail_with($sformatf("timed out waiting for ack to become %0d", level));
            end
        end
    endtask

    task automatic send_bundle(input logic [VLIW_WIDTH-1:0] b, output int edges);
        instruction = b;
        req         = 1'b1;
        wait_ack(1'b1, edges);
    endtask

    task automatic release_req();
        int edges;
        @(negedge clk);
        check_value("ack", 32'd1, 32'(ack));    // Still high until req drops
        req = 1'b0;
        wait_ack(1'b0, edges);
    endtask

    task automatic check_slot(input int i, input logic [31:0] s);
        logic [3:0] cat;
        logic [7:0] op;
        cat = s[31:28];
        op  = s[27:20];
        check_value($sformatf("alu_enable[%0d]", i), 32'(cat == CAT_ALU), 32'(alu_enable[i]));
        check_value($sformatf("alu_operation[%0d]", i), 32'(expect_alu_op(s)),
                    32'(alu_operation[i]));
        check_value($sformatf("memory_enable[%0d]", i), 32'(cat == CAT_MEMORY),
                    32'(memory_enable[i]));
        check_value($sformatf("memory_write[%0d]", i),
                    32'(cat == CAT_MEMORY && (op == MEM_STORE || op == MEM_PUSH)),
                    32'(memory_write[i]));
        check_value($sformatf("rs1[%0d]", i), 32'(s[19:16]), 32'(rs1[i]));
        check_value($sformatf("rs2[%0d]", i), 32'(s[15:12]), 32'(rs2[i]));
        check_value($sformatf("rd[%0d]", i), 32'(expect_rd(s)), 32'(rd[i]));
        check_value($sformatf("immediate[%0d]", i), 32'(s[7:0]), 32'(immediate[i]));
    endtask

    // Branch result comes from slot A alone
    task automatic check_bundle(input logic [VLIW_WIDTH-1:0] b);
        logic [31:0] a;
        a = b[31:0];
        for (int i = 0; i < SLOT_COUNT; i++) begin
            check_slot(i, b[i*SLOT_WIDTH +: SLOT_WIDTH]);
        end
        check_value("branch_enable", 32'(a[31:28] == CAT_BRANCH), 32'(branch_enable));
        check_value("branch_condition", 32'(expect_cond(a)), 32'(branch_condition));
        check_value("branch_target", expect_target(a), branch_target);
        check_value("error", 32'd0, 32'(error));
        check_value("error_code", 32'(ERR_NONE), 32'(error_code));
    endtask

    task automatic run_legal(input logic [VLIW_WIDTH-1:0] b, input int hold);
        int edges;
        send_bundle(b, edges);
        bundles_sent++;
        check_value("ack latency", 32'd5, 32'(edges));  // Sample edge plus four
        check_bundle(b);
        check_value("decode_count", 32'(bundles_sent), decode_count);
        for (int n = 0; n < hold; n++) begin
            @(negedge clk);
            check_value("ack", 32'd1, 32'(ack));
            check_bundle(b);
        end
        release_req();
    endtask

    task automatic run_fault(input logic [VLIW_WIDTH-1:0] b,
                             input logic [ERROR_CODE_WIDTH-1:0] code, input bit probe);
        int edges;
        send_bundle(b, edges);
        bundles_sent++;
        faults_seen++;
        check_value("error", 32'd1, 32'(error));
        check_value("error_code", 32'(code), 32'(error_code));
        check_value("error_count", 32'(faults_seen), error_count);
        check_value("decode_count", 32'(bundles_sent), decode_count);
        check_value("enables", 32'd0,
                    32'({alu_enable, memory_enable, memory_write, branch_enable}));
        release_req();
        if (probe) begin
            instruction = random_bundle();
            req         = 1'b1;
            for (int n = 0; n < IGNORE_CYCLES; n++) begin
                @(negedge clk);
                if (ack !== 1'b0) begin
                    fail_with("decoder acknowledged a request while in the error state");
                end
            end
            req = 1'b0;
            @(negedge clk);
            check_value("decode_count", 32'(bundles_sent), decode_count);
        end
        error_clear = 1'b1;
        @(negedge clk);
        error_clear = 1'b0;
        check_value("error", 32'd0, 32'(error));
        check_value("error_code", 32'(ERR_NONE), 32'(error_code));
    endtask

    // ==========================================================================
    // Test sequence
    // ==========================================================================
    initial begin
        logic [31:0] slot_a;
        logic [31:0] slot_b;
        logic [31:0] bad;
        rst_n        = 1'b0;
        req          = 1'b0;
        error_clear  = 1'b0;
        instruction  = '0;
        lcg_state    = 32'h6c93;
        bundles_sent = 0;
        faults_seen  = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_value("ack", 32'd0, 32'(ack));
        check_value("error", 32'd0, 32'(error));
        check_value("enables", 32'd0,
                    32'({alu_enable, memory_enable, memory_write, branch_enable}));
        check_value("decode_count", 32'd0, decode_count);
        check_value("error_count", 32'd0, error_count);
        check_value("error_code", 32'(ERR_NONE), 32'(error_code));

        for (int n = 0; n < 40; n++) begin
            run_legal(random_bundle(), 0);
        end

        // Every branch op in slot A with positive and negative offsets
        for (int k = 0; k < 10; k++) begin
            slot_a = make_slot({CAT_BRANCH, BR_JUMP + 8'(k)}, 4'h1, 4'h2, 4'h4, 8'h05);
            run_legal({random_slot(), random_slot(), slot_a}, 0);
            slot_a[7:0] = 8'h86;
            run_legal({random_slot(), random_slot(), slot_a}, 0);
        end
        slot_a = make_slot({CAT_ALU, ALU_ADD}, 4'h1, 4'h2, 4'h4, 8'h05);
        slot_b = make_slot({CAT_BRANCH, BR_BRANCH_EQ}, 4'h2, 4'h1, 4'h0, 8'h86);
        run_legal({random_slot(), slot_b, slot_a}, 0);

        run_legal(random_bundle(), 10);     // Back-pressure

        bad = make_slot({CAT_ALU, 8'h1D}, 4'h1, 4'h2, 4'h4, 8'h05);
        run_fault({random_slot(), bad, random_slot()}, ERR_INVALID_OP, 1'b1);
        run_legal(random_bundle(), 0);

        bad = make_slot(random_opcode(), 4'h1, 4'h3, 4'h4, 8'h05);     // rs2 trit 11
        run_fault({bad, random_slot(), random_slot()}, ERR_INVALID_ADDR, 1'b0);
        bad = make_slot(random_opcode(), 4'h1, 4'h2, 4'h4, 8'h13);     // imm trit 11
        run_fault({random_slot(), random_slot(), bad}, ERR_INVALID_OP, 1'b0);
        bad = make_slot({4'h5, 8'h11}, 4'hC, 4'h2, 4'h4, 8'h05);       // both faults
        run_fault({random_slot(), random_slot(), bad}, ERR_INVALID_OP, 1'b0);
        run_legal(random_bundle(), 0);

        check_value("error_count", 32'(faults_seen), error_count);
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+test
hw/vliw_decoder_pkg.sv
hw/slot_checker.sv
hw/slot_decoder.sv
hw/decode_result_bank.sv
hw/decode_sequencer.sv
hw/vliw_decoder_top.sv
test/tb_vliw_decoder.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run to sim.log, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_vliw_decoder -Mdir obj_dir \
    && ./obj_dir/Vtb_vliw_decoder > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qs "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
